// File: Bender.yml
package:
  name: cache_aq_sys

export_include_dirs:
  - include

sources:
  - src/cache_aq_pkg.sv
  - src/aq_fifo.sv
  - src/aq_arbiter.sv
  - src/aq_req_mux.sv
  - src/cache_aq_sys.sv
  - target: test
    files:
      - verification/cache_aq_props.sv
      - verification/cache_aq_sys_tb.sv

// File: cache_aq_sys.f
+incdir+include
src/cache_aq_pkg.sv
src/aq_fifo.sv
src/aq_arbiter.sv
src/aq_req_mux.sv
src/cache_aq_sys.sv
verification/cache_aq_props.sv
verification/cache_aq_sys_tb.sv

// File: include/cache_aq_macros.svh
`ifndef CACHE_AQ_MACROS_SVH
`define CACHE_AQ_MACROS_SVH

// physical line address of one bank
`define AQ_ADDR_W 15

// data per bank, the byte mask uses one bit per data bit
`define AQ_DATA_W 32

// queue geometry
`define AQ_DEPTH 8
`define AQ_PTR_W 3

`endif

// File: src/aq_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module aq_arbiter import cache_aq_pkg::*; (
    input  wire logic read_i,
    input  wire logic bus_isempty_i,
    input  wire logic rd_empty_i,
    input  wire logic sw_empty_i,
    input  wire logic wb_empty_i,
    output aq_src_e   src_o,
    output logic      rd_pop_o,
    output logic      sw_pop_o,
    output logic      wb_pop_o,
    output logic      aq_isempty_o
);

    // fixed priority, bus over wb over sw over rd
    always_comb begin
        if (!bus_isempty_i) begin
            src_o = AQ_SRC_BUS;
        end else if (!wb_empty_i) begin
            src_o = AQ_SRC_WB;
        end else if (!sw_empty_i) begin
            src_o = AQ_SRC_SW;
        end else if (!rd_empty_i) begin
            src_o = AQ_SRC_RD;
        end else begin
            src_o = AQ_SRC_NONE;
        end
    end

    // bus buffer pops itself, so no strobe for AQ_SRC_BUS
    assign wb_pop_o = read_i && (src_o == AQ_SRC_WB);
    assign sw_pop_o = read_i && (src_o == AQ_SRC_SW);
    assign rd_pop_o = read_i && (src_o == AQ_SRC_RD);

    assign aq_isempty_o = bus_isempty_i && wb_empty_i && sw_empty_i && rd_empty_i;

endmodule

`default_nettype wire

// File: src/aq_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_aq_macros.svh"

module aq_fifo import cache_aq_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    arst_n_i,
    input  wire logic    clr_i,
    input  wire logic    push_i,
    input  wire logic    pop_i,
    input  wire aq_req_t req_i,
    output aq_req_t      head_o,
    output logic         empty_o,
    output logic         full_o
);

    localparam int CNT_W = `AQ_PTR_W + 1;

    aq_req_t mem_q [`AQ_DEPTH];

    logic [`AQ_PTR_W-1:0] wr_ptr_q;
    logic [`AQ_PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0]     cnt_q;
    logic                 push_ok;
    logic                 pop_ok;

    assign empty_o = (cnt_q == '0);
    assign full_o  = (cnt_q == CNT_W'(`AQ_DEPTH));

    assign push_ok = push_i && !full_o && !clr_i; // dropped when full
    assign pop_ok  = pop_i && !empty_o && !clr_i;

    // first word fallthrough
    assign head_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (clr_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            unique case ({push_ok, pop_ok})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/aq_req_mux.sv
`timescale 1ns/10ps
`default_nettype none

module aq_req_mux import cache_aq_pkg::*; (
    input  wire aq_src_e src_i,
    input  wire aq_req_t rd_head_i,
    input  wire aq_req_t sw_head_i,
    input  wire aq_req_t wb_head_i,
    input  wire aq_req_t bus_req_i,
    output aq_req_t      req_o
);

    aq_req_t bus_fill;

    // fill entries write whole lines
    always_comb begin
        bus_fill               = '0;
        bus_fill.valid_e       = bus_req_i.valid_e;
        bus_fill.valid_o       = bus_req_i.valid_o;
        bus_fill.paddr_e       = bus_req_i.paddr_e;
        bus_fill.paddr_o       = bus_req_i.paddr_o;
        bus_fill.data_e        = bus_req_i.data_e;
        bus_fill.data_o        = bus_req_i.data_o;
        bus_fill.aux.mask      = '1; // all bytes written
        bus_fill.pcd           = bus_req_i.pcd;
    end

    always_comb begin
        unique case (src_i)
            AQ_SRC_BUS: req_o = bus_fill;
            AQ_SRC_WB:  req_o = wb_head_i;
            AQ_SRC_SW:  req_o = sw_head_i;
            AQ_SRC_RD:  req_o = rd_head_i;
            default:    req_o = '0; // nothing granted, valids low
        endcase
    end

endmodule

`default_nettype wire

// File: src/cache_aq_pkg.sv
`default_nettype none

`include "cache_aq_macros.svh"

package cache_aq_pkg;

    localparam int AQ_AUX_W     = 2 * `AQ_DATA_W;
    localparam int AQ_PTCINFO_W = AQ_AUX_W - 7 - 8; // whatever is left after ptcid and qslot

    // protection view of the aux word, rd and sw entries
    typedef struct packed {
        logic [6:0]              ptcid;
        logic [7:0]              qslot;
        logic [AQ_PTCINFO_W-1:0] ptcinfo;
    } aq_ptc_t;

    // mask view of the aux word, wb and bus entries
    typedef struct packed {
        logic [`AQ_DATA_W-1:0] mask_e;
        logic [`AQ_DATA_W-1:0] mask_o;
    } aq_mask_t;

    typedef union packed {
        aq_ptc_t  ptc;
        aq_mask_t mask;
    } aq_aux_u;

    typedef struct packed {
        logic                  valid_e;
        logic                  valid_o;
        logic [`AQ_ADDR_W-1:0] paddr_e;
        logic [`AQ_ADDR_W-1:0] paddr_o;
        logic [`AQ_DATA_W-1:0] data_e;
        logic [`AQ_DATA_W-1:0] data_o;
        logic [1:0]            size_e;
        logic [1:0]            size_o;
        aq_aux_u               aux;
        logic                  odd_is_greater;
        logic                  need_p1;
        logic [2:0]            one_size;
        logic                  pcd;
    } aq_req_t;

    typedef enum logic [2:0] {
        AQ_SRC_NONE = 3'd0,
        AQ_SRC_RD   = 3'd1,
        AQ_SRC_SW   = 3'd2,
        AQ_SRC_WB   = 3'd3,
        AQ_SRC_BUS  = 3'd4
    } aq_src_e;

endpackage

`default_nettype wire

// File: src/cache_aq_sys.sv
`timescale 1ns/10ps
`default_nettype none

module cache_aq_sys import cache_aq_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    arst_n_i,
    input  wire logic    rdsw_clr_i,
    input  wire logic    wb_clr_i,
    input  wire aq_req_t rd_req_i,
    input  wire aq_req_t sw_req_i,
    input  wire aq_req_t wb_req_i,
    input  wire logic    rd_write_i,
    input  wire logic    sw_write_i,
    input  wire logic    wb_write_i,
    input  wire aq_req_t bus_req_i,
    input  wire logic    bus_isempty_i,
    input  wire logic    read_i,
    output aq_req_t      req_o,
    output aq_src_e      src_o,
    output logic         aq_isempty_o,
    output logic         rdaq_isfull_o,
    output logic         swaq_isfull_o,
    output logic         wbaq_isfull_o
);

    aq_req_t rd_head;
    aq_req_t sw_head;
    aq_req_t wb_head;
    logic    rd_empty;
    logic    sw_empty;
    logic    wb_empty;
    logic    rd_pop;
    logic    sw_pop;
    logic    wb_pop;

    aq_fifo u_rdaq (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .clr_i    (rdsw_clr_i),
        .push_i   (rd_write_i),
        .pop_i    (rd_pop),
        .req_i    (rd_req_i),
        .head_o   (rd_head),
        .empty_o  (rd_empty),
        .full_o   (rdaq_isfull_o)
    );

    aq_fifo u_swaq (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .clr_i    (rdsw_clr_i), // shared flush with rd
        .push_i   (sw_write_i),
        .pop_i    (sw_pop),
        .req_i    (sw_req_i),
        .head_o   (sw_head),
        .empty_o  (sw_empty),
        .full_o   (swaq_isfull_o)
    );

    aq_fifo u_wbaq (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .clr_i    (wb_clr_i),
        .push_i   (wb_write_i),
        .pop_i    (wb_pop),
        .req_i    (wb_req_i),
        .head_o   (wb_head),
        .empty_o  (wb_empty),
        .full_o   (wbaq_isfull_o)
    );

    aq_arbiter u_arbiter (
        .read_i        (read_i),
        .bus_isempty_i (bus_isempty_i),
        .rd_empty_i    (rd_empty),
        .sw_empty_i    (sw_empty),
        .wb_empty_i    (wb_empty),
        .src_o         (src_o),
        .rd_pop_o      (rd_pop),
        .sw_pop_o      (sw_pop),
        .wb_pop_o      (wb_pop),
        .aq_isempty_o  (aq_isempty_o)
    );

    aq_req_mux u_req_mux (
        .src_i     (src_o),
        .rd_head_i (rd_head),
        .sw_head_i (sw_head),
        .wb_head_i (wb_head),
        .bus_req_i (bus_req_i),
        .req_o     (req_o)
    );

endmodule

`default_nettype wire

// File: verification/cache_aq_props.sv
`timescale 1ns/10ps
`default_nettype none

module cache_aq_props import cache_aq_pkg::*; (
    input wire logic    clk_i,
    input wire logic    arst_n_i,
    input wire logic    rd_pop_i,
    input wire logic    sw_pop_i,
    input wire logic    wb_pop_i,
    input wire logic    rd_empty_i,
    input wire logic    sw_empty_i,
    input wire logic    wb_empty_i,
    input wire logic    bus_isempty_i,
    input wire logic    aq_isempty_i,
    input wire aq_src_e src_i,
    input wire aq_req_t req_i
);

    one_pop_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({rd_pop_i, sw_pop_i, wb_pop_i}))
        else $error("more than one queue popped in a cycle");

    pop_nonempty_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(rd_pop_i && rd_empty_i) && !(sw_pop_i && sw_empty_i) && !(wb_pop_i && wb_empty_i))
        else $error("pop of an empty queue");

    bus_first_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !bus_isempty_i |-> src_i == AQ_SRC_BUS)
        else $error("bus entry pending but not granted");

    idle_invalid_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        aq_isempty_i |-> !req_i.valid_e && !req_i.valid_o)
        else $error("valid request while all sources empty");

endmodule

bind cache_aq_sys cache_aq_props u_props (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .rd_pop_i      (rd_pop),
    .sw_pop_i      (sw_pop),
    .wb_pop_i      (wb_pop),
    .rd_empty_i    (rd_empty),
    .sw_empty_i    (sw_empty),
    .wb_empty_i    (wb_empty),
    .bus_isempty_i (bus_isempty_i),
    .aq_isempty_i  (aq_isempty_o),
    .src_i         (src_o),
    .req_i         (req_o)
);

`default_nettype wire

// File: verification/cache_aq_sys_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_aq_macros.svh"

module cache_aq_sys_tb import cache_aq_pkg::*;;

    logic    clk;
    logic    arst_n;
    logic    rdsw_clr;
    logic    wb_clr;
    logic    rd_write;
    logic    sw_write;
    logic    wb_write;
    logic    bus_isempty;
    logic    read;
    aq_req_t rd_req;
    aq_req_t sw_req;
    aq_req_t wb_req;
    aq_req_t bus_req;
    aq_req_t req;
    aq_src_e src;
    logic    aq_isempty;
    logic    rdaq_isfull;
    logic    swaq_isfull;
    logic    wbaq_isfull;

    aq_req_t rd_mq[$]; // queue models
    aq_req_t sw_mq[$];
    aq_req_t wb_mq[$];

    int errors       = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    cache_aq_sys dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .rdsw_clr_i    (rdsw_clr),
        .wb_clr_i      (wb_clr),
        .rd_req_i      (rd_req),
        .sw_req_i      (sw_req),
        .wb_req_i      (wb_req),
        .rd_write_i    (rd_write),
        .sw_write_i    (sw_write),
        .wb_write_i    (wb_write),
        .bus_req_i     (bus_req),
        .bus_isempty_i (bus_isempty),
        .read_i        (read),
        .req_o         (req),
        .src_o         (src),
        .aq_isempty_o  (aq_isempty),
        .rdaq_isfull_o (rdaq_isfull),
        .swaq_isfull_o (swaq_isfull),
        .wbaq_isfull_o (wbaq_isfull)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected grant and request from the model heads
    function automatic aq_req_t expected_req(input logic bus_empty, output aq_src_e exp_src);
        aq_req_t r;
        r = '0;
        exp_src = AQ_SRC_NONE;
        if (!bus_empty) begin
            exp_src = AQ_SRC_BUS;
            r.valid_e = bus_req.valid_e;
            r.valid_o = bus_req.valid_o;
            r.paddr_e = bus_req.paddr_e;
            r.paddr_o = bus_req.paddr_o;
            r.data_e = bus_req.data_e;
            r.data_o = bus_req.data_o;
            r.aux.mask.mask_e = '1; // full line fill
            r.aux.mask.mask_o = '1;
            r.pcd = bus_req.pcd;
        end else if (wb_mq.size() > 0) begin
            exp_src = AQ_SRC_WB;
            r = wb_mq[0];
        end else if (sw_mq.size() > 0) begin
            exp_src = AQ_SRC_SW;
            r = sw_mq[0];
        end else if (rd_mq.size() > 0) begin
            exp_src = AQ_SRC_RD;
            r = rd_mq[0];
        end
        return r;
    endfunction

    function automatic aq_req_t rand_req();
        logic [191:0] bits;
        aq_req_t      r;
        bits = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
        r = bits[$bits(aq_req_t)-1:0]; // any aux word is legal in either view
        r.valid_e = 1'b1;
        return r;
    endfunction

    task automatic flag_error(input string name, input logic [255:0] exp_v,
                              input logic [255:0] act_v);
        $display("ERROR %s expected %0h got %0h at %0t", name, exp_v, act_v, $time);
        test_errors++;
    endtask

    // compare just before the rising edge, then advance the model
    initial begin
        aq_src_e exp_src;
        aq_req_t exp_req;
        logic    exp_empty;
        logic    rd_full;
        logic    sw_full;
        logic    wb_full;
        forever begin
            @(negedge clk);
            #4;
            if (arst_n) begin
                exp_req = expected_req(bus_isempty, exp_src);
                exp_empty = bus_isempty && (rd_mq.size() == 0) && (sw_mq.size() == 0)
                            && (wb_mq.size() == 0);
                rd_full = (rd_mq.size() == `AQ_DEPTH);
                sw_full = (sw_mq.size() == `AQ_DEPTH);
                wb_full = (wb_mq.size() == `AQ_DEPTH);
                if (src !== exp_src) flag_error("src_o", 256'(exp_src), 256'(src));
                if (req !== exp_req) flag_error("req_o", 256'(exp_req), 256'(req));
                if (aq_isempty !== exp_empty)
                    flag_error("aq_isempty_o", 256'(exp_empty), 256'(aq_isempty));
                if (rdaq_isfull !== rd_full)
                    flag_error("rdaq_isfull_o", 256'(rd_full), 256'(rdaq_isfull));
                if (swaq_isfull !== sw_full)
                    flag_error("swaq_isfull_o", 256'(sw_full), 256'(swaq_isfull));
                if (wbaq_isfull !== wb_full)
                    flag_error("wbaq_isfull_o", 256'(wb_full), 256'(wbaq_isfull));
                if (read && exp_src == AQ_SRC_WB) wb_mq.delete(0);
                if (read && exp_src == AQ_SRC_SW) sw_mq.delete(0);
                if (read && exp_src == AQ_SRC_RD) rd_mq.delete(0);
                if (rd_write && !rd_full) rd_mq.push_back(rd_req); // full drops it
                if (sw_write && !sw_full) sw_mq.push_back(sw_req);
                if (wb_write && !wb_full) wb_mq.push_back(wb_req);
                if (rdsw_clr) begin
                    rd_mq.delete();
                    sw_mq.delete();
                end
                if (wb_clr) wb_mq.delete();
            end
        end
    end

    task automatic push_n(input int n, input logic [2:0] which);
        for (int i = 0; i < n; i++) begin
            rd_req = rand_req();
            sw_req = rand_req();
            wb_req = rand_req();
            rd_write = which[0];
            sw_write = which[1];
            wb_write = which[2];
            @(negedge clk);
        end
        rd_write = 1'b0;
        sw_write = 1'b0;
        wb_write = 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        read = 1'b1;
        while (!aq_isempty && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        read = 1'b0;
        if (!aq_isempty) begin
            $display("timeout, the queues did not drain within 100 cycles");
            $display("Some tests failed");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        void'($urandom(95));
        arst_n = 1'b0;
        {rdsw_clr, wb_clr, rd_write, sw_write, wb_write, read} = '0;
        bus_isempty = 1'b1;
        rd_req = '0;
        sw_req = '0;
        wb_req = '0;
        bus_req = '0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        bus_req = rand_req();
        bus_isempty = 1'b0;
        push_n(3, 3'b111);
        read = 1'b1; // bus pending, queues must hold
        repeat (3) @(negedge clk);
        read = 1'b0;
        bus_isempty = 1'b1;
        drain();
        end_test("priority");

        push_n(5, 3'b111);
        drain();
        end_test("fifo order");

        push_n(9, 3'b111); // ninth push dropped
        drain();
        end_test("capacity");

        push_n(2, 3'b111);
        bus_req = rand_req();
        bus_isempty = 1'b0;
        read = 1'b1;
        repeat (4) @(negedge clk);
        read = 1'b0;
        bus_req = rand_req();
        @(negedge clk);
        bus_isempty = 1'b1;
        drain();
        end_test("bus fill");

        push_n(7, 3'b111);
        push_n(1, 3'b110); // rd one short of full, sw and wb full
        rdsw_clr = 1'b1;
        rd_write = 1'b1; // flush wins over push
        rd_req = rand_req();
        @(negedge clk);
        rdsw_clr = 1'b0;
        rd_write = 1'b0;
        @(negedge clk);
        wb_clr = 1'b1;
        @(negedge clk);
        wb_clr = 1'b0;
        if (!aq_isempty) begin
            $display("queues not empty after both flushes");
            test_errors++;
        end
        end_test("flushes");

        for (int i = 0; i < 60; i++) begin
            rd_req = rand_req();
            sw_req = rand_req();
            wb_req = rand_req();
            rd_write = 1'($urandom);
            sw_write = 1'($urandom);
            wb_write = 1'($urandom);
            read = 1'($urandom);
            @(negedge clk);
        end
        {rd_write, sw_write, wb_write, read} = '0;
        drain();
        end_test("union views");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
